/* cpuPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants of the 8-bit CPU
// Instruction encoding, opcodes, variant bits, FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpuPkg;

  // One data byte, used for registers, constants and ASCII characters
  typedef logic [7:0] word_t;

  // Program byte address; jump targets are byte addresses too
  typedef logic [7:0] progAddr_t;

  // The eight operations in the 3-bit opcode field
  typedef enum logic [2:0] {
    CLR  = 3'd0,
    ADD  = 3'd1,
    STA  = 3'd2,
    INV  = 3'd3,
    PRNT = 3'd4,
    JMPZ = 3'd5,
    WAIT = 3'd6,
    HLT  = 3'd7
  } opcode_t;

  // One-hot variant field, so every option decodes from a single bit
  typedef logic [3:0] variant_t;

  // Bit positions inside the variant field
  localparam int selA   = 3;
  localparam int selB   = 2;
  localparam int selC   = 1;
  localparam int selBtn = 1;  // CLR reuses the C bit for the button
  localparam int selAc  = 0;
  localparam int selLed = 0;  // STA reuses the AC bit for the LEDs

  // Opcode byte layout with the constant flag in bit 7
  typedef struct packed {
    logic     isConst;
    opcode_t  op;
    variant_t variant;
  } instr_t;

  // Screen position, 4 rows of 16 characters
  typedef logic [5:0] charIndex_t;
  typedef logic [5:0] leds_t;

  localparam int    numChars  = 64;
  localparam word_t blankChar = 8'h20;

  // Controller states, one instruction in flight at a time
  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    RETRIEVE,
    EXECUTE,
    WAITING,
    HALTED
  } cpuState_t;

endpackage

/* cpuControl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU controller FSM and program counter
// Fetch, decode, retrieve, execute, wait and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpuControl (
  input  logic                EXT_CLK,
  input  logic                rst,
  input  logic                memReady,
  input  cpuPkg::word_t       memData,
  input  logic                acZero,
  input  cpuPkg::word_t       regOperand,
  input  logic                waitDone,
  output logic                memReq,
  output cpuPkg::progAddr_t   memAddr,
  output cpuPkg::instr_t      instr,
  output cpuPkg::word_t       constOperand,
  output logic                execPulse,
  output logic                waitStart,
  output cpuPkg::word_t       waitMs,
  output logic                halted
);

  cpuPkg::cpuState_t state;
  cpuPkg::progAddr_t pc;
  cpuPkg::word_t     operand;
  logic              memDone;

  // A program byte arrives in the cycle where a pending request meets ready
  assign memDone = memReq && memReady;

  // The address is the PC itself, so it stays put while the request waits
  assign memAddr = pc;

  // Constant variants take the retrieved byte, the rest a register
  assign operand = instr.isConst ? constOperand : regOperand;

  assign execPulse = (state == cpuPkg::EXECUTE);
  assign waitStart = execPulse && (instr.op == cpuPkg::WAIT);
  assign waitMs    = operand;
  assign halted    = (state == cpuPkg::HALTED);

  // Instruction and constant bytes are captured straight off the port
  always_ff @(posedge EXT_CLK) begin
    if ((state == cpuPkg::FETCH) && memDone) begin
      instr <= memData;
    end
    if ((state == cpuPkg::RETRIEVE) && memDone) begin
      constOperand <= memData;
    end
  end

  always_ff @(posedge EXT_CLK) begin
    if (rst) begin
      state  <= cpuPkg::FETCH;
      pc     <= '0;
      memReq <= 1'b0;
    end else begin
      case (state)
        cpuPkg::FETCH: begin
          // Only the first fetch after reset gets here with no request up
          if (!memReq) begin
            memReq <= 1'b1;
          end else if (memReady) begin
            memReq <= 1'b0;
            pc     <= pc + 8'd1;
            state  <= cpuPkg::DECODE;
          end
        end
        cpuPkg::DECODE: begin
          // A constant flag means one more byte follows the opcode
          if (instr.isConst) begin
            memReq <= 1'b1;
            state  <= cpuPkg::RETRIEVE;
          end else begin
            state <= cpuPkg::EXECUTE;
          end
        end
        cpuPkg::RETRIEVE: begin
          if (memDone) begin
            memReq <= 1'b0;
            pc     <= pc + 8'd1;
            state  <= cpuPkg::EXECUTE;
          end
        end
        cpuPkg::EXECUTE: begin
          case (instr.op)
            cpuPkg::JMPZ: begin
              // Target and request go out on the same edge
              if (acZero) begin
                pc <= operand;
              end
              memReq <= 1'b1;
              state  <= cpuPkg::FETCH;
            end
            cpuPkg::WAIT: state <= cpuPkg::WAITING;
            cpuPkg::HLT:  state <= cpuPkg::HALTED;
            default: begin
              // Register effects happen in the datapath on this same pulse
              memReq <= 1'b1;
              state  <= cpuPkg::FETCH;
            end
          endcase
        end
        cpuPkg::WAITING: begin
          if (waitDone) begin
            memReq <= 1'b1;
            state  <= cpuPkg::FETCH;
          end
        end
        cpuPkg::HALTED: begin
          // Parked until reset
          state <= cpuPkg::HALTED;
        end
        default: state <= cpuPkg::FETCH;
      endcase
    end
  end

endmodule

/* waitTimer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Millisecond timer for the WAIT instruction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module waitTimer #(
  parameter int clkFreqHz = 27000000
) (
  input  logic          EXT_CLK,
  input  logic          rst,
  input  logic          waitStart,
  input  cpuPkg::word_t waitMs,
  output logic          waitDone
);

  localparam int cyclesPerMs = clkFreqHz / 1000;
  localparam int preW        = (cyclesPerMs > 1) ? $clog2(cyclesPerMs) : 1;
  localparam logic [preW-1:0] preLast = preW'(cyclesPerMs - 1);

  logic            active;
  logic            zeroDone;
  logic [preW-1:0] prescale;
  cpuPkg::word_t   msLeft;
  logic            lastCycle;

  // Done lands on the final cycle of the final millisecond
  assign lastCycle = active && (msLeft == 8'd1) && (prescale == preLast);
  assign waitDone  = zeroDone || lastCycle;

  always_ff @(posedge EXT_CLK) begin
    if (rst) begin
      active   <= 1'b0;
      zeroDone <= 1'b0;
      prescale <= '0;
      msLeft   <= '0;
    end else begin
      // A zero wait simply answers on the next cycle
      zeroDone <= waitStart && (waitMs == 8'd0);
      if (waitStart && (waitMs != 8'd0)) begin
        active   <= 1'b1;
        msLeft   <= waitMs;
        prescale <= '0;
      end else if (active) begin
        if (prescale == preLast) begin
          prescale <= '0;
          msLeft   <= msLeft - 8'd1;
          if (msLeft == 8'd1) begin
            active <= 1'b0;
          end
        end else begin
          prescale <= prescale + 1'b1;
        end
      end
    end
  end

endmodule

/* cpuDatapath.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU datapath: AC, A, B, C, adder and inverter
// Button synchronizer, LED register, screen writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpuDatapath (
  input  logic                EXT_CLK,
  input  logic                rst,
  input  logic                btn,
  input  cpuPkg::instr_t      instr,
  input  cpuPkg::word_t       constOperand,
  input  logic                execPulse,
  output logic                acZero,
  output cpuPkg::word_t       regOperand,
  output cpuPkg::leds_t       leds,
  output logic                scrWrite,
  output cpuPkg::charIndex_t  scrIndex,
  output cpuPkg::word_t       scrChar
);

  cpuPkg::word_t   ac;
  cpuPkg::word_t   regA;
  cpuPkg::word_t   regB;
  cpuPkg::word_t   regC;
  cpuPkg::word_t   operand;
  cpuPkg::variant_t sel;
  logic            btnMeta;
  logic            btnSync;

  assign sel    = instr.variant;
  assign acZero = (ac == 8'd0);

  // Register operand for ADD, PRNT, JMPZ and WAIT, picked by the one-hot variant
  always_comb begin
    if (sel[cpuPkg::selA]) begin
      regOperand = regA;
    end else if (sel[cpuPkg::selB]) begin
      regOperand = regB;
    end else begin
      regOperand = regC;
    end
  end

  assign operand = instr.isConst ? constOperand : regOperand;

  // Two flops bring the board button into the clock domain
  always_ff @(posedge EXT_CLK) begin
    if (rst) begin
      btnMeta <= 1'b0;
      btnSync <= 1'b0;
    end else begin
      btnMeta <= btn;
      btnSync <= btnMeta;
    end
  end

  always_ff @(posedge EXT_CLK) begin
    if (rst) begin
      ac   <= '0;
      regA <= '0;
      regB <= '0;
      regC <= '0;
      leds <= '0;
    end else if (execPulse) begin
      case (instr.op)
        cpuPkg::CLR: begin
          if (sel[cpuPkg::selA]) regA <= '0;
          if (sel[cpuPkg::selB]) regB <= '0;
          // CLR BTN only clears while the button is held
          if (sel[cpuPkg::selBtn] && btnSync) ac <= '0;
          if (sel[cpuPkg::selAc]) ac <= '0;
        end
        cpuPkg::ADD: ac <= ac + operand;
        cpuPkg::STA: begin
          if (sel[cpuPkg::selA]) regA <= ac;
          if (sel[cpuPkg::selB]) regB <= ac;
          if (sel[cpuPkg::selC]) regC <= ac;
          if (sel[cpuPkg::selLed]) leds <= ac[5:0];
        end
        cpuPkg::INV: begin
          if (sel[cpuPkg::selA]) regA <= ~regA;
          if (sel[cpuPkg::selB]) regB <= ~regB;
          if (sel[cpuPkg::selC]) regC <= ~regC;
          if (sel[cpuPkg::selAc]) ac <= ~ac;
        end
        default: ac <= ac;
      endcase
    end
  end

  // Screen writes leave one cycle after the PRNT execute pulse
  always_ff @(posedge EXT_CLK) begin
    if (rst) begin
      scrWrite <= 1'b0;
    end else begin
      scrWrite <= execPulse && (instr.op == cpuPkg::PRNT);
    end
  end

  // AC holds the screen index and wraps at 64
  always_ff @(posedge EXT_CLK) begin
    scrIndex <= ac[5:0];
    scrChar  <= operand;
  end

endmodule

/* screenBuffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64-character screen memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module screenBuffer (
  input  logic               EXT_CLK,
  input  logic               rst,
  input  logic               scrWrite,
  input  cpuPkg::charIndex_t scrIndex,
  input  cpuPkg::word_t      scrChar,
  input  cpuPkg::charIndex_t charAddress,
  output cpuPkg::word_t      charOutput
);

  cpuPkg::word_t mem [cpuPkg::numChars];

  // One port shared by CPU and display, the CPU write wins the cycle
  always_ff @(posedge EXT_CLK) begin
    if (rst) begin
      // Blank screen after reset
      for (int i = 0; i < cpuPkg::numChars; i++) begin
        mem[i] <= cpuPkg::blankChar;
      end
      charOutput <= cpuPkg::blankChar;
    end else if (scrWrite) begin
      mem[scrIndex] <= scrChar;
    end else begin
      // The display read stalls during a write and keeps its old value
      charOutput <= mem[charAddress];
    end
  end

endmodule

/* cpuTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU top level
// Controller, timer, datapath and screen buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpuTop #(
  parameter int clkFreqHz = 27000000
) (
  input  logic               EXT_CLK,
  input  logic               rst,
  input  logic               btn,
  input  logic               memReady,
  input  cpuPkg::word_t      memData,
  input  cpuPkg::charIndex_t charAddress,
  output logic               memReq,
  output cpuPkg::progAddr_t  memAddr,
  output cpuPkg::leds_t      leds,
  output cpuPkg::word_t      charOutput,
  output logic               halted
);

  // Controller to datapath
  cpuPkg::instr_t     instr;
  cpuPkg::word_t      constOperand;
  logic               execPulse;
  logic               acZero;
  cpuPkg::word_t      regOperand;

  // Controller to timer
  logic               waitStart;
  cpuPkg::word_t      waitMs;
  logic               waitDone;

  // Datapath to screen memory
  logic               scrWrite;
  cpuPkg::charIndex_t scrIndex;
  cpuPkg::word_t      scrChar;

  cpuControl control (
    .EXT_CLK      (EXT_CLK),
    .rst          (rst),
    .memReady     (memReady),
    .memData      (memData),
    .acZero       (acZero),
    .regOperand   (regOperand),
    .waitDone     (waitDone),
    .memReq       (memReq),
    .memAddr      (memAddr),
    .instr        (instr),
    .constOperand (constOperand),
    .execPulse    (execPulse),
    .waitStart    (waitStart),
    .waitMs       (waitMs),
    .halted       (halted)
  );

  waitTimer #(
    .clkFreqHz (clkFreqHz)
  ) timer (
    .EXT_CLK   (EXT_CLK),
    .rst       (rst),
    .waitStart (waitStart),
    .waitMs    (waitMs),
    .waitDone  (waitDone)
  );

  cpuDatapath datapath (
    .EXT_CLK      (EXT_CLK),
    .rst          (rst),
    .btn          (btn),
    .instr        (instr),
    .constOperand (constOperand),
    .execPulse    (execPulse),
    .acZero       (acZero),
    .regOperand   (regOperand),
    .leds         (leds),
    .scrWrite     (scrWrite),
    .scrIndex     (scrIndex),
    .scrChar      (scrChar)
  );

  screenBuffer screen (
    .EXT_CLK     (EXT_CLK),
    .rst         (rst),
    .scrWrite    (scrWrite),
    .scrIndex    (scrIndex),
    .scrChar     (scrChar),
    .charAddress (charAddress),
    .charOutput  (charOutput)
  );

endmodule

/* cpuTop_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions on the program port and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpuTopProperties (
  input logic              EXT_CLK,
  input logic              rst,
  input logic              memReq,
  input logic              memReady,
  input cpuPkg::progAddr_t memAddr,
  input logic              halted
);

  // Reset drops any request in flight
  assert property (@(posedge EXT_CLK) rst |=> !memReq)
    else $error("memReq high in the cycle after reset");

  // A waiting read keeps its address until the byte is taken
  assert property (@(posedge EXT_CLK) disable iff (rst)
                   (memReq && !memReady) |=> $stable(memAddr))
    else $error("memAddr moved while a read was pending");

  // HALTED issues no reads
  assert property (@(posedge EXT_CLK) disable iff (rst) halted |-> !memReq)
    else $error("memReq high while halted");

  // Only reset leaves HALTED
  assert property (@(posedge EXT_CLK) disable iff (rst) halted |=> halted)
    else $error("halted dropped without reset");

endmodule

/* cpuTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the 8-bit CPU with clock, reset, program memory
// responder, ISA model, compare tasks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpuTb;

  localparam int clkFreqHz   = 5000;
  localparam int cyclesPerMs = clkFreqHz / 1000;
  localparam int margin      = 2000;

  // Variant bits as the instruction set defines them
  localparam logic [3:0] vA = 4'b1000;
  localparam logic [3:0] vB = 4'b0100;
  localparam logic [3:0] vC = 4'b0010;
  localparam logic [3:0] vK = 4'b0001;

  logic               EXT_CLK     = 1'b0;
  logic               rst         = 1'b1;
  logic               btn         = 1'b0;
  logic               memReady    = 1'b0;
  cpuPkg::word_t      memData     = '0;
  cpuPkg::charIndex_t charAddress = '0;
  logic               memReq;
  cpuPkg::progAddr_t  memAddr;
  cpuPkg::leds_t      leds;
  cpuPkg::word_t      charOutput;
  logic               halted;

  integer seed     = 32'h7f8e4b6a;
  int     cycle    = 0;
  int     deadline = 1000;
  int     delayMax = 5;

  // Program image and the button level planned for each CLR BTN opcode address
  cpuPkg::word_t prog [256];
  bit            btnHere [256];
  bit            btnVal [256];
  int            wrPtr;

  // Results predicted by the ISA model
  cpuPkg::word_t     mScreen [cpuPkg::numChars];
  cpuPkg::leds_t     mLeds;
  int                mReads;
  int                mWaitMs;
  cpuPkg::progAddr_t expAddr [$];
  cpuPkg::leds_t     ledLog [$];

  bit                pending  = 1'b0;
  cpuPkg::progAddr_t reqAddr;
  int                delayLeft;
  cpuPkg::leds_t     lastLeds = '0;

  cpuTop #(
    .clkFreqHz (clkFreqHz)
  ) DUT (
    .EXT_CLK     (EXT_CLK),
    .rst         (rst),
    .btn         (btn),
    .memReady    (memReady),
    .memData     (memData),
    .charAddress (charAddress),
    .memReq      (memReq),
    .memAddr     (memAddr),
    .leds        (leds),
    .charOutput  (charOutput),
    .halted      (halted)
  );

  bind cpuTop cpuTopProperties props (
    .EXT_CLK  (EXT_CLK),
    .rst      (rst),
    .memReq   (memReq),
    .memReady (memReady),
    .memAddr  (memAddr),
    .halted   (halted)
  );

  initial begin
    forever #10 EXT_CLK = ~EXT_CLK;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input cpuPkg::word_t got,
                           input cpuPkg::word_t exp);
    if (got !== exp) begin
      abortRun($sformatf("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic checkLeds(input string name, input cpuPkg::leds_t got,
                           input cpuPkg::leds_t exp);
    if (got !== exp) begin
      abortRun($sformatf("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic checkAddr(input string name, input cpuPkg::progAddr_t got,
                           input cpuPkg::progAddr_t exp);
    if (got !== exp) begin
      abortRun($sformatf("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  function automatic int randRange(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // The opcode byte packs the constant flag, the operation and the one-hot variant
  function automatic cpuPkg::word_t encode(input bit isConst, input cpuPkg::opcode_t op,
                                           input logic [3:0] variant);
    return {isConst, op, variant};
  endfunction

  task automatic putInstr(input bit isConst, input cpuPkg::opcode_t op,
                          input logic [3:0] variant, input cpuPkg::word_t k);
    prog[wrPtr] = encode(isConst, op, variant);
    wrPtr++;
    if (isConst) begin
      prog[wrPtr] = k;
      wrPtr++;
    end
  endtask

  task automatic clearProg();
    for (int i = 0; i < 256; i++) begin
      prog[i]    = 8'(i) ^ 8'hA5;
      btnHere[i] = 1'b0;
      btnVal[i]  = 1'b0;
    end
    wrPtr = 0;
  endtask

  // Load AC with a likely nonzero value, CLR BTN, then show AC on the LEDs
  task automatic putClrBtn();
    putInstr(1'b1, cpuPkg::ADD, vK, 8'($random(seed)) | 8'h01);
    btnHere[wrPtr] = 1'b1;
    btnVal[wrPtr]  = 1'($random(seed));
    putInstr(1'b0, cpuPkg::CLR, vC, 8'h00);
    putInstr(1'b0, cpuPkg::STA, vK, 8'h00);
  endtask

  task automatic genStraight();
    int            i;
    cpuPkg::word_t k;
    logic [3:0]    v;
    logic [3:0]    r;
    clearProg();
    for (i = 0; i < 40; i++) begin
      k = 8'($random(seed));
      v = vK << randRange(4);
      r = vA >> randRange(3);
      case (randRange(6))
        0: begin
          if (v == vC) begin
            putClrBtn();
          end else begin
            putInstr(1'b0, cpuPkg::CLR, v, 8'h00);
          end
        end
        1: putInstr(randRange(2) == 0, cpuPkg::ADD, (k[0] ? vK : r), k);
        2: putInstr(1'b0, cpuPkg::STA, v, 8'h00);
        3: putInstr(1'b0, cpuPkg::INV, v, 8'h00);
        4: begin
          if (k[7]) begin
            putInstr(1'b1, cpuPkg::PRNT, vK, k);
          end else begin
            putInstr(1'b0, cpuPkg::PRNT, r, 8'h00);
          end
        end
        default: putClrBtn();
      endcase
    end
    putInstr(1'b0, cpuPkg::HLT, 4'b0000, 8'h00);
  endtask

  task automatic genCountdown(input int n);
    cpuPkg::progAddr_t loopAt;
    cpuPkg::progAddr_t exitFix;
    clearProg();
    putInstr(1'b1, cpuPkg::ADD, vK, 8'(n));
    putInstr(1'b0, cpuPkg::STA, vA, 8'h00);
    loopAt = 8'(wrPtr);
    putInstr(1'b0, cpuPkg::CLR, vK, 8'h00);
    putInstr(1'b0, cpuPkg::ADD, vA, 8'h00);
    putInstr(1'b1, cpuPkg::PRNT, vK, 8'h2A);
    // Decrement as ~(~x + 1)
    putInstr(1'b0, cpuPkg::INV, vK, 8'h00);
    putInstr(1'b1, cpuPkg::ADD, vK, 8'h01);
    putInstr(1'b0, cpuPkg::INV, vK, 8'h00);
    putInstr(1'b0, cpuPkg::STA, vA, 8'h00);
    putInstr(1'b0, cpuPkg::STA, vK, 8'h00);
    exitFix = 8'(wrPtr + 1);
    putInstr(1'b1, cpuPkg::JMPZ, vK, 8'h00);
    // Clearing AC turns the next JMPZ into an unconditional jump
    putInstr(1'b0, cpuPkg::CLR, vK, 8'h00);
    putInstr(1'b1, cpuPkg::JMPZ, vK, loopAt);
    prog[exitFix] = 8'(wrPtr);
    putInstr(1'b1, cpuPkg::PRNT, vK, 8'h21);
    putInstr(1'b0, cpuPkg::HLT, 4'b0000, 8'h00);
  endtask

  task automatic genWaits();
    clearProg();
    putInstr(1'b1, cpuPkg::ADD, vK, 8'(randRange(6)));
    putInstr(1'b0, cpuPkg::STA, vB, 8'h00);
    putInstr(1'b0, cpuPkg::WAIT, vB, 8'h00);
    putInstr(1'b1, cpuPkg::WAIT, vK, 8'(randRange(6)));
    putInstr(1'b1, cpuPkg::ADD, vK, 8'(randRange(4)));
    putInstr(1'b0, cpuPkg::STA, vC, 8'h00);
    putInstr(1'b0, cpuPkg::WAIT, vC, 8'h00);
    // Zero duration still passes through the timer
    putInstr(1'b1, cpuPkg::WAIT, vK, 8'h00);
    putInstr(1'b0, cpuPkg::STA, vK, 8'h00);
    putInstr(1'b0, cpuPkg::HLT, 4'b0000, 8'h00);
  endtask

  // The ISA model walks the program and records reads, LED updates, screen and waits
  task automatic runModel();
    cpuPkg::progAddr_t pc;
    cpuPkg::progAddr_t opAddr;
    cpuPkg::word_t     op;
    cpuPkg::word_t     k;
    cpuPkg::word_t     val;
    cpuPkg::word_t     ac;
    cpuPkg::word_t     ra;
    cpuPkg::word_t     rb;
    cpuPkg::word_t     rc;
    logic [3:0]        v;
    bit                done;
    int                steps;
    pc      = '0;
    ac      = '0;
    ra      = '0;
    rb      = '0;
    rc      = '0;
    mLeds   = '0;
    mWaitMs = 0;
    done    = 1'b0;
    steps   = 0;
    expAddr.delete();
    ledLog.delete();
    for (int i = 0; i < cpuPkg::numChars; i++) begin
      mScreen[i] = 8'h20;
    end
    while (!done) begin
      if (steps > 1000) begin
        abortRun("The model program never reached HLT");
      end
      opAddr = pc;
      op     = prog[pc];
      expAddr.push_back(pc);
      pc = pc + 8'd1;
      k  = '0;
      if (op[7]) begin
        k = prog[pc];
        expAddr.push_back(pc);
        pc = pc + 8'd1;
      end
      v = op[3:0];
      // Operand is the constant byte, else the register that the variant names
      if (op[7]) begin
        val = k;
      end else if (v[3]) begin
        val = ra;
      end else if (v[2]) begin
        val = rb;
      end else begin
        val = rc;
      end
      case (op[6:4])
        cpuPkg::CLR: begin
          if (v[3]) ra = '0;
          if (v[2]) rb = '0;
          if (v[1] && btnVal[opAddr]) ac = '0;
          if (v[0]) ac = '0;
        end
        cpuPkg::ADD: ac = ac + val;
        cpuPkg::STA: begin
          if (v[3]) ra = ac;
          if (v[2]) rb = ac;
          if (v[1]) rc = ac;
          if (v[0]) begin
            if (ac[5:0] != mLeds) ledLog.push_back(ac[5:0]);
            mLeds = ac[5:0];
          end
        end
        cpuPkg::INV: begin
          if (v[3]) ra = ~ra;
          if (v[2]) rb = ~rb;
          if (v[1]) rc = ~rc;
          if (v[0]) ac = ~ac;
        end
        cpuPkg::PRNT: mScreen[ac[5:0]] = val;
        cpuPkg::JMPZ: begin
          if (ac == 8'd0) pc = val;
        end
        cpuPkg::WAIT: mWaitMs = mWaitMs + int'(val);
        default: done = 1'b1;
      endcase
      steps++;
    end
    mReads = expAddr.size();
  endtask

  // Reset is already high on entry and stays high for 10 rising edges
  task automatic runProgram(input int maxDelay);
    int start;
    runModel();
    delayMax = maxDelay;
    deadline = cycle + 10 + mReads * 7 + mWaitMs * cyclesPerMs + margin;
    repeat (10) @(posedge EXT_CLK);
    rst <= 1'b0;
    @(negedge EXT_CLK);
    start = cycle;
    while (!halted) begin
      @(negedge EXT_CLK);
    end
    if (cycle - start < mWaitMs * cyclesPerMs) begin
      abortRun($sformatf("Halted after %0d cycles, before %0d cycles of waiting",
                         cycle - start, mWaitMs * cyclesPerMs));
    end
    if (expAddr.size() != 0) begin
      abortRun("The processor halted before reading every program byte");
    end
    if (ledLog.size() != 0) begin
      abortRun("Some LED updates of the model never appeared");
    end
    checkLeds("leds", leds, mLeds);
    // Screen readout has one cycle of latency
    for (int i = 0; i < cpuPkg::numChars; i++) begin
      @(posedge EXT_CLK);
      charAddress <= 6'(i);
      @(posedge EXT_CLK);
      @(negedge EXT_CLK);
      checkWord("charOutput", charOutput, mScreen[i]);
    end
    // Hold the DUT in reset until the next program starts
    @(posedge EXT_CLK);
    rst <= 1'b1;
  endtask

  // Program memory responder with a random delay per read
  always @(posedge EXT_CLK) begin
    if (rst) begin
      memReady <= 1'b0;
      btn      <= 1'b0;
      pending = 1'b0;
    end else if (memReady) begin
      // The DUT takes the byte on this edge
      memReady <= 1'b0;
      pending = 1'b0;
    end else if (memReq) begin
      if (!pending) begin
        if (expAddr.size() == 0) begin
          abortRun("The processor read past the end of the model's program");
        end
        checkAddr("memAddr", memAddr, expAddr.pop_front());
        pending   = 1'b1;
        reqAddr   = memAddr;
        delayLeft = (delayMax == 0) ? 0 : randRange(delayMax + 1);
      end else if (memAddr !== reqAddr) begin
        abortRun("memAddr changed while a program read was pending");
      end
      if (delayLeft == 0) begin
        memReady <= 1'b1;
        memData  <= prog[reqAddr];
        // The button level for a CLR BTN is set with its opcode byte and held after
        if (btnHere[reqAddr]) btn <= btnVal[reqAddr];
      end else begin
        delayLeft--;
      end
    end
  end

  // Every LED change must be the next update the model predicts
  always @(posedge EXT_CLK) begin
    if (rst) begin
      lastLeds = '0;
    end else if (leds !== lastLeds) begin
      if (ledLog.size() == 0) begin
        abortRun("The LEDs changed when the model predicts no update");
      end
      checkLeds("leds", leds, ledLog.pop_front());
      lastLeds = leds;
    end
  end

  always @(posedge EXT_CLK) begin
    cycle++;
    if (cycle > deadline) begin
      abortRun($sformatf("Timeout: the program gave no result by cycle %0d", cycle));
    end
  end

  initial begin
    // Each random program runs with random delays, then again with none
    for (int t = 0; t < 4; t++) begin
      genStraight();
      runProgram(5);
      runProgram(0);
    end
    for (int t = 0; t < 3; t++) begin
      genCountdown(1 + randRange(8));
      runProgram(5);
    end
    for (int t = 0; t < 3; t++) begin
      genWaits();
      runProgram(5);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* tinyCpu.f */
cpuPkg.sv
cpuControl.sv
waitTimer.sv
cpuDatapath.sv
screenBuffer.sv
cpuTop.sv
cpuTop_properties.sv
cpuTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpuTb
FILELIST = tinyCpu.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
